// ==== design/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int XLEN = 32;

    typedef logic [4:0] reg_idx_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for BRANCH
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // funct7, SUB is the only alternate encoding kept
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // Branch offset is scattered over the word, bit 0 is implicit
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
    } instr_u;

endpackage

// ==== design/pipe_pkg.sv ====
package pipe_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // Decode to execute payload
    typedef struct packed {
        logic                          valid;
        logic [rv_isa_pkg::XLEN-1:0]   pc;
        rv_isa_pkg::reg_idx_t          rs1;
        rv_isa_pkg::reg_idx_t          rs2;
        rv_isa_pkg::reg_idx_t          rd;
        logic [rv_isa_pkg::XLEN-1:0]   rs1_data;
        logic [rv_isa_pkg::XLEN-1:0]   rs2_data;
        logic [rv_isa_pkg::XLEN-1:0]   imm;
        // Second ALU operand comes from imm instead of rs2
        logic                          use_imm;
        alu_op_e                       alu_op;
        logic                          wr_en;
        logic                          is_branch;
        // Set for BNE, clear for BEQ
        logic                          branch_ne;
    } id_ex_t;

endpackage

// ==== design/if_id_intf.sv ====
interface if_id_intf;

    logic                          valid;
    logic [rv_isa_pkg::XLEN-1:0]   pc;
    rv_isa_pkg::instr_u            instr;
    // Taken branch in execute, kills what fetch holds
    logic                          flush;

    modport fetch (
        output valid,
        output pc,
        output instr,
        input  flush
    );

    modport decode (
        input valid,
        input pc,
        input instr
    );

endinterface

// ==== design/fetch.sv ====
module fetch #(
    parameter logic [rv_isa_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic                          imem_req_o,
    output logic [rv_isa_pkg::XLEN-1:0]   imem_addr_o,
    input  logic                          imem_ack_i,
    input  logic [rv_isa_pkg::XLEN-1:0]   imem_rdata_i,
    input  logic                          redirect_valid_i,
    input  logic [rv_isa_pkg::XLEN-1:0]   redirect_pc_i,
    if_id_intf.fetch                      if_id
);

    localparam logic [rv_isa_pkg::XLEN-1:0] PC_STEP = 4;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_ACK,
        S_WAIT_LOW,
        S_DISCARD
    } state_e;

    state_e                        state_q;
    logic                          req_q;
    logic [rv_isa_pkg::XLEN-1:0]   pc_q;
    logic [rv_isa_pkg::XLEN-1:0]   addr_q;
    logic                          start_req;
    logic                          fetch_done;

    // New request only once the previous ack has dropped
    assign start_req  = (state_q == S_IDLE || state_q == S_WAIT_LOW) && !imem_ack_i;
    assign fetch_done = (state_q == S_WAIT_ACK) && imem_ack_i;

    assign imem_req_o  = req_q;
    assign imem_addr_o = addr_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            req_q   <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE, S_WAIT_LOW: begin
                    if (start_req) begin
                        req_q   <= 1'b1;
                        state_q <= S_WAIT_ACK;
                    end
                end
                S_WAIT_ACK: begin
                    if (imem_ack_i) begin
                        req_q   <= 1'b0;
                        state_q <= S_WAIT_LOW;
                    end else if (redirect_valid_i) begin
                        state_q <= S_DISCARD;
                    end
                end
                // Close the stale handshake, data is dropped
                S_DISCARD: begin
                    if (imem_ack_i) begin
                        req_q   <= 1'b0;
                        state_q <= S_WAIT_LOW;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // pc_q is the next address to request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (redirect_valid_i) begin
            pc_q <= redirect_pc_i;
        end else if (fetch_done) begin
            pc_q <= addr_q + PC_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (start_req) begin
            addr_q <= redirect_valid_i ? redirect_pc_i : pc_q;
        end
    end

    // Fetch to decode register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_id.valid <= 1'b0;
        end else begin
            if_id.valid <= fetch_done && !if_id.flush;
        end
    end

    always_ff @(posedge clk) begin
        if (if_id.flush) begin
            if_id.instr <= rv_isa_pkg::NOP_INSTR;
        end else if (fetch_done) begin
            if_id.pc    <= addr_q;
            if_id.instr <= imem_rdata_i;
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req_o |=> !imem_req_o || $stable(imem_addr_o));

endmodule

// ==== design/decode.sv ====
module decode (
    input  logic                          clk,
    input  logic                          rst_n,
    if_id_intf.decode                     if_id,
    input  logic                          flush_i,
    input  logic                          wb_valid_i,
    input  rv_isa_pkg::reg_idx_t          wb_rd_i,
    input  logic [rv_isa_pkg::XLEN-1:0]   wb_data_i,
    output pipe_pkg::id_ex_t              id_ex_o
);

    rv_isa_pkg::instr_u                   instr;
    logic [rv_isa_pkg::XLEN-1:0]          imm_i;
    logic [rv_isa_pkg::XLEN-1:0]          imm_b;
    logic [rv_isa_pkg::XLEN-1:0]          imm_u;
    pipe_pkg::id_ex_t                     id_ex_d;
    // x1..x31, x0 has no storage
    logic [31:1][rv_isa_pkg::XLEN-1:0]    regs;

    assign instr = if_id.instr;

    // Sign-extended immediates, one per format
    assign imm_i = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
    assign imm_b = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                    instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {instr.u_fmt.imm_31_12, 12'b0};

    always_comb begin
        id_ex_d           = '0;
        id_ex_d.valid     = if_id.valid;
        id_ex_d.pc        = if_id.pc;
        id_ex_d.rs1       = instr.r_fmt.rs1;
        id_ex_d.rs2       = instr.r_fmt.rs2;
        id_ex_d.rd        = instr.r_fmt.rd;
        id_ex_d.alu_op    = pipe_pkg::ALU_ADD;

        case (instr.r_fmt.opcode)
            rv_isa_pkg::OPC_OP: begin
                id_ex_d.wr_en = 1'b1;
                case (instr.r_fmt.funct3)
                    rv_isa_pkg::F3_ADD_SUB: begin
                        if (instr.r_fmt.funct7 == rv_isa_pkg::F7_SUB) begin
                            id_ex_d.alu_op = pipe_pkg::ALU_SUB;
                        end
                    end
                    rv_isa_pkg::F3_SLT: id_ex_d.alu_op = pipe_pkg::ALU_SLT;
                    rv_isa_pkg::F3_XOR: id_ex_d.alu_op = pipe_pkg::ALU_XOR;
                    rv_isa_pkg::F3_OR:  id_ex_d.alu_op = pipe_pkg::ALU_OR;
                    rv_isa_pkg::F3_AND: id_ex_d.alu_op = pipe_pkg::ALU_AND;
                    default:            id_ex_d.wr_en  = 1'b0;
                endcase
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                id_ex_d.wr_en   = 1'b1;
                id_ex_d.use_imm = 1'b1;
                id_ex_d.imm     = imm_i;
                case (instr.i_fmt.funct3)
                    rv_isa_pkg::F3_ADD_SUB: id_ex_d.alu_op = pipe_pkg::ALU_ADD;
                    rv_isa_pkg::F3_XOR:     id_ex_d.alu_op = pipe_pkg::ALU_XOR;
                    rv_isa_pkg::F3_OR:      id_ex_d.alu_op = pipe_pkg::ALU_OR;
                    rv_isa_pkg::F3_AND:     id_ex_d.alu_op = pipe_pkg::ALU_AND;
                    default:                id_ex_d.wr_en  = 1'b0;
                endcase
            end
            rv_isa_pkg::OPC_LUI: begin
                id_ex_d.wr_en   = 1'b1;
                id_ex_d.use_imm = 1'b1;
                id_ex_d.imm     = imm_u;
                id_ex_d.alu_op  = pipe_pkg::ALU_PASS_B;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                id_ex_d.is_branch = 1'b1;
                id_ex_d.imm       = imm_b;
                id_ex_d.branch_ne = (instr.b_fmt.funct3 == rv_isa_pkg::F3_BNE);
            end
            default: id_ex_d.wr_en = 1'b0;
        endcase

        // Register reads, a write in this same cycle wins
        if (id_ex_d.rs1 == '0) begin
            id_ex_d.rs1_data = '0;
        end else if (wb_valid_i && wb_rd_i == id_ex_d.rs1) begin
            id_ex_d.rs1_data = wb_data_i;
        end else begin
            id_ex_d.rs1_data = regs[id_ex_d.rs1];
        end
        if (id_ex_d.rs2 == '0) begin
            id_ex_d.rs2_data = '0;
        end else if (wb_valid_i && wb_rd_i == id_ex_d.rs2) begin
            id_ex_d.rs2_data = wb_data_i;
        end else begin
            id_ex_d.rs2_data = regs[id_ex_d.rs2];
        end
    end

    always_ff @(posedge clk) begin
        if (wb_valid_i && wb_rd_i != '0) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // Decode to execute register, only valid is cleared
    always_ff @(posedge clk) begin
        id_ex_o <= id_ex_d;
        if (!rst_n || flush_i) begin
            id_ex_o.valid <= 1'b0;
        end
    end

    a_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid_i && wb_rd_i == '0 |=> $stable(regs));

endmodule

// ==== design/execute.sv ====
module execute (
    input  logic                          clk,
    input  logic                          rst_n,
    input  pipe_pkg::id_ex_t              id_ex_i,
    output logic                          redirect_valid_o,
    output logic [rv_isa_pkg::XLEN-1:0]   redirect_pc_o,
    output logic                          flush_o,
    output logic                          wb_valid_o,
    output rv_isa_pkg::reg_idx_t          wb_rd_o,
    output logic [rv_isa_pkg::XLEN-1:0]   wb_data_o,
    output logic                          retire_valid_o,
    output logic [rv_isa_pkg::XLEN-1:0]   retire_pc_o,
    output rv_isa_pkg::reg_idx_t          retire_rd_o,
    output logic [rv_isa_pkg::XLEN-1:0]   retire_data_o
);

    logic                          fwd_rs1;
    logic                          fwd_rs2;
    logic [rv_isa_pkg::XLEN-1:0]   op_a;
    logic [rv_isa_pkg::XLEN-1:0]   op_b_reg;
    logic [rv_isa_pkg::XLEN-1:0]   alu_b;
    logic [rv_isa_pkg::XLEN-1:0]   alu_result;
    logic                          operands_eq;
    logic                          branch_taken;
    logic                          writes_rd;

    logic                          retire_valid_q;
    logic [rv_isa_pkg::XLEN-1:0]   retire_pc_q;
    rv_isa_pkg::reg_idx_t          retire_rd_q;
    logic [rv_isa_pkg::XLEN-1:0]   retire_data_q;

    // Forward from the writeback register unless it targets x0
    assign fwd_rs1 = wb_valid_o && (wb_rd_o != '0) && (wb_rd_o == id_ex_i.rs1);
    assign fwd_rs2 = wb_valid_o && (wb_rd_o != '0) && (wb_rd_o == id_ex_i.rs2);

    assign op_a     = fwd_rs1 ? wb_data_o : id_ex_i.rs1_data;
    assign op_b_reg = fwd_rs2 ? wb_data_o : id_ex_i.rs2_data;
    assign alu_b    = id_ex_i.use_imm ? id_ex_i.imm : op_b_reg;

    always_comb begin
        case (id_ex_i.alu_op)
            pipe_pkg::ALU_ADD:    alu_result = op_a + alu_b;
            pipe_pkg::ALU_SUB:    alu_result = op_a - alu_b;
            pipe_pkg::ALU_AND:    alu_result = op_a & alu_b;
            pipe_pkg::ALU_OR:     alu_result = op_a | alu_b;
            pipe_pkg::ALU_XOR:    alu_result = op_a ^ alu_b;
            pipe_pkg::ALU_SLT: begin
                alu_result = {{(rv_isa_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            end
            pipe_pkg::ALU_PASS_B: alu_result = alu_b;
            default:              alu_result = '0;
        endcase
    end

    // BEQ and BNE share the comparator, BNE inverts it
    assign operands_eq  = (op_a == op_b_reg);
    assign branch_taken = id_ex_i.valid && id_ex_i.is_branch
                          && (operands_eq ^ id_ex_i.branch_ne);

    assign redirect_valid_o = branch_taken;
    assign redirect_pc_o    = id_ex_i.pc + id_ex_i.imm;
    assign flush_o          = branch_taken;

    // Branches and writes to x0 retire with rd and data zero
    assign writes_rd = id_ex_i.wr_en && (id_ex_i.rd != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid_q <= 1'b0;
        end else begin
            retire_valid_q <= id_ex_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        retire_pc_q   <= id_ex_i.pc;
        retire_rd_q   <= writes_rd ? id_ex_i.rd : '0;
        retire_data_q <= writes_rd ? alu_result : '0;
    end

    // One register feeds both the register file write and the retire port
    assign wb_valid_o = retire_valid_q;
    assign wb_rd_o    = retire_rd_q;
    assign wb_data_o  = retire_data_q;

    assign retire_valid_o = retire_valid_q;
    assign retire_pc_o    = retire_pc_q;
    assign retire_rd_o    = retire_rd_q;
    assign retire_data_o  = retire_data_q;

    // Redirect comes from a live branch and the slot behind it is flushed
    a_redirect_valid: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid_o |-> id_ex_i.valid ##1 !id_ex_i.valid);

endmodule

// ==== design/pipeline_top.sv ====
module pipeline_top #(
    parameter logic [rv_isa_pkg::XLEN-1:0] RESET_PC = 32'h8000_0000
) (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic                          imem_req_o,
    output logic [rv_isa_pkg::XLEN-1:0]   imem_addr_o,
    input  logic                          imem_ack_i,
    input  logic [rv_isa_pkg::XLEN-1:0]   imem_rdata_i,
    output logic                          retire_valid_o,
    output logic [rv_isa_pkg::XLEN-1:0]   retire_pc_o,
    output rv_isa_pkg::reg_idx_t          retire_rd_o,
    output logic [rv_isa_pkg::XLEN-1:0]   retire_data_o
);

    pipe_pkg::id_ex_t                     id_ex;
    logic                                 wb_valid;
    rv_isa_pkg::reg_idx_t                 wb_rd;
    logic [rv_isa_pkg::XLEN-1:0]          wb_data;
    logic                                 redirect_valid;
    logic [rv_isa_pkg::XLEN-1:0]          redirect_pc;
    logic                                 flush;

    if_id_intf u_if_id ();

    assign u_if_id.flush = flush;

    fetch #(
        .RESET_PC         (RESET_PC)
    ) u_fetch (
        .clk              (clk),
        .rst_n            (rst_n),
        .imem_req_o       (imem_req_o),
        .imem_addr_o      (imem_addr_o),
        .imem_ack_i       (imem_ack_i),
        .imem_rdata_i     (imem_rdata_i),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .if_id            (u_if_id.fetch)
    );

    decode u_decode (
        .clk              (clk),
        .rst_n            (rst_n),
        .if_id            (u_if_id.decode),
        .flush_i          (flush),
        .wb_valid_i       (wb_valid),
        .wb_rd_i          (wb_rd),
        .wb_data_i        (wb_data),
        .id_ex_o          (id_ex)
    );

    execute u_execute (
        .clk              (clk),
        .rst_n            (rst_n),
        .id_ex_i          (id_ex),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc),
        .flush_o          (flush),
        .wb_valid_o       (wb_valid),
        .wb_rd_o          (wb_rd),
        .wb_data_o        (wb_data),
        .retire_valid_o   (retire_valid_o),
        .retire_pc_o      (retire_pc_o),
        .retire_rd_o      (retire_rd_o),
        .retire_data_o    (retire_data_o)
    );

endmodule

// ==== bench/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Instruction kinds of the random program
localparam int K_ADD     = 0;
localparam int K_SUB     = 1;
localparam int K_AND     = 2;
localparam int K_OR      = 3;
localparam int K_XOR     = 4;
localparam int K_SLT     = 5;
localparam int K_ADDI    = 6;
localparam int K_ANDI    = 7;
localparam int K_ORI     = 8;
localparam int K_XORI    = 9;
localparam int K_LUI     = 10;
localparam int K_BEQ     = 11;
localparam int K_BNE     = 12;
localparam int NUM_KINDS = 13;

typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] data;
} retire_t;

logic [31:0] rand_state = 32'h3e8c;
int          kind_a    [NUM_INSTR];
logic [4:0]  rd_a      [NUM_INSTR];
logic [4:0]  rs1_a     [NUM_INSTR];
logic [4:0]  rs2_a     [NUM_INSTR];
// Operand value for ALU kinds, byte offset for branches
logic [31:0] imm_a     [NUM_INSTR];
logic [31:0] prog_word [NUM_INSTR];
retire_t     expected_q [$];

function automatic logic [31:0] next_random();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
endfunction

function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
    rv_isa_pkg::instr_u w;
    w.r_fmt.funct7 = f7;
    w.r_fmt.rs2    = rs2;
    w.r_fmt.rs1    = rs1;
    w.r_fmt.funct3 = f3;
    w.r_fmt.rd     = rd;
    w.r_fmt.opcode = rv_isa_pkg::OPC_OP;
    return w;
endfunction

function automatic logic [31:0] i_type_word(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
    rv_isa_pkg::instr_u w;
    w.i_fmt.imm_11_0 = imm;
    w.i_fmt.rs1      = rs1;
    w.i_fmt.funct3   = f3;
    w.i_fmt.rd       = rd;
    w.i_fmt.opcode   = rv_isa_pkg::OPC_OP_IMM;
    return w;
endfunction

function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
    rv_isa_pkg::instr_u w;
    w.u_fmt.imm_31_12 = imm;
    w.u_fmt.rd        = rd;
    w.u_fmt.opcode    = rv_isa_pkg::OPC_LUI;
    return w;
endfunction

function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
    rv_isa_pkg::instr_u w;
    w.b_fmt.imm_12   = off[12];
    w.b_fmt.imm_10_5 = off[10:5];
    w.b_fmt.rs2      = rs2;
    w.b_fmt.rs1      = rs1;
    w.b_fmt.funct3   = f3;
    w.b_fmt.imm_4_1  = off[4:1];
    w.b_fmt.imm_11   = off[11];
    w.b_fmt.opcode   = rv_isa_pkg::OPC_BRANCH;
    return w;
endfunction

function automatic logic [31:0] encode_instr(input int i);
    logic [2:0] f3;
    logic [6:0] f7;
    f7 = (kind_a[i] == K_SUB) ? rv_isa_pkg::F7_SUB : rv_isa_pkg::F7_BASE;
    case (kind_a[i])
        K_SLT:         f3 = rv_isa_pkg::F3_SLT;
        K_AND, K_ANDI: f3 = rv_isa_pkg::F3_AND;
        K_OR, K_ORI:   f3 = rv_isa_pkg::F3_OR;
        K_XOR, K_XORI: f3 = rv_isa_pkg::F3_XOR;
        K_BEQ:         f3 = rv_isa_pkg::F3_BEQ;
        K_BNE:         f3 = rv_isa_pkg::F3_BNE;
        default:       f3 = rv_isa_pkg::F3_ADD_SUB;
    endcase
    case (kind_a[i])
        K_ADDI, K_ANDI, K_ORI, K_XORI: begin
            return i_type_word(f3, rd_a[i], rs1_a[i], imm_a[i][11:0]);
        end
        K_LUI:        return lui_word(rd_a[i], imm_a[i][31:12]);
        K_BEQ, K_BNE: return branch_word(f3, rs1_a[i], rs2_a[i], imm_a[i][12:0]);
        default:      return r_type_word(f7, f3, rd_a[i], rs1_a[i], rs2_a[i]);
    endcase
endfunction

task automatic build_program();
    logic [31:0] r;
    logic [31:0] s;
    int          span;
    int          i;
    for (i = 0; i < NUM_INSTR; i++) begin
        r = next_random();
        s = next_random();
        kind_a[i] = int'((r >> 24) % NUM_KINDS);
        // Only x0..x7, so dependences are frequent
        rd_a[i]  = {2'b00, r[23:21]};
        rs1_a[i] = {2'b00, r[20:18]};
        rs2_a[i] = {2'b00, r[17:15]};
        imm_a[i] = {{20{s[31]}}, s[31:20]};
        // Prologue gives x1..x7 a defined value
        if (i < 7) begin
            kind_a[i] = K_ADDI;
            rd_a[i]   = 5'(i + 1);
            rs1_a[i]  = '0;
        end
        if (kind_a[i] == K_LUI) begin
            imm_a[i] = {s[31:12], 12'b0};
        end
        if (kind_a[i] == K_BEQ || kind_a[i] == K_BNE) begin
            span = 1 + int'(s[30:28]);
            if (span > NUM_INSTR - 1 - i) begin
                span = NUM_INSTR - 1 - i;
            end
            imm_a[i] = 32'(span * 4);
        end
        // Closing self-loop
        if (i == NUM_INSTR - 1) begin
            kind_a[i] = K_BEQ;
            rs1_a[i]  = '0;
            rs2_a[i]  = '0;
            imm_a[i]  = '0;
        end
        prog_word[i] = encode_instr(i);
    end
endtask

// In-order execution, one queue entry per retired instruction
task automatic run_reference_model();
    logic [31:0] xr [8];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        taken;
    retire_t     e;
    int          idx;
    bit          stop;
    foreach (xr[k]) begin
        xr[k] = '0;
    end
    idx  = 0;
    stop = 1'b0;
    while (!stop) begin
        a      = xr[rs1_a[idx][2:0]];
        b      = xr[rs2_a[idx][2:0]];
        e.pc   = RESET_PC + 32'(idx) * 32'd4;
        e.rd   = '0;
        e.data = '0;
        case (kind_a[idx])
            K_ADD:   res = a + b;
            K_SUB:   res = a - b;
            K_AND:   res = a & b;
            K_OR:    res = a | b;
            K_XOR:   res = a ^ b;
            K_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            K_ADDI:  res = a + imm_a[idx];
            K_ANDI:  res = a & imm_a[idx];
            K_ORI:   res = a | imm_a[idx];
            K_XORI:  res = a ^ imm_a[idx];
            default: res = imm_a[idx];
        endcase
        if (kind_a[idx] == K_BEQ || kind_a[idx] == K_BNE) begin
            taken = (a == b) ^ (kind_a[idx] == K_BNE);
            stop  = (idx == NUM_INSTR - 1);
            idx   = taken ? idx + int'(imm_a[idx] >> 2) : idx + 1;
        end else begin
            // x0 stays zero and retires as rd 0
            if (rd_a[idx] != '0) begin
                xr[rd_a[idx][2:0]] = res;
                e.rd               = rd_a[idx];
                e.data             = res;
            end
            idx = idx + 1;
        end
        expected_q.push_back(e);
    end
endtask

`endif

// ==== bench/tb_pipeline_top.sv ====
module tb_pipeline_top;

    localparam int          CLK_PERIOD     = 100;
    localparam int          DRIVE_DLY      = 10;
    localparam int          RESET_CYCLES   = 4;
    localparam int          NUM_INSTR      = 200;
    // Up to 8 cycles per fetch plus pipeline slack
    localparam int          TIMEOUT_CYCLES = NUM_INSTR * (8 + 4) + 100;
    localparam logic [31:0] RESET_PC       = 32'h0000_1000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        imem_ack;
    logic [31:0] imem_rdata;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    int          checks    = 0;
    int          errors    = 0;
    int          cycles    = 0;
    bit          done      = 1'b0;
    bit          first_req = 1'b1;
    logic        prev_req  = 1'b0;
    logic        prev_ack  = 1'b0;
    logic [31:0] prev_addr = '0;

    `include "tb_model.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    pipeline_top #(
        .RESET_PC       (RESET_PC)
    ) u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .imem_req_o     (imem_req),
        .imem_addr_o    (imem_addr),
        .imem_ack_i     (imem_ack),
        .imem_rdata_i   (imem_rdata),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_rd_o    (retire_rd),
        .retire_data_o  (retire_data)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic wait_drive_slot();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - RESET_PC;
        // Outside the program only wrong-path fetches land
        if (addr[1:0] != 2'b00 || addr < RESET_PC || (offset >> 2) >= NUM_INSTR) begin
            return rv_isa_pkg::NOP_INSTR;
        end
        return prog_word[offset >> 2];
    endfunction

    // Program order has unique pcs since branches only go forward
    task automatic check_retirement();
        retire_t head;
        int      pos;
        pos = -1;
        foreach (expected_q[k]) begin
            if (pos < 0 && expected_q[k].pc == retire_pc) begin
                pos = k;
            end
        end
        check_value("retire_pc_o", retire_pc, expected_q[0].pc);
        if (pos < 0) begin
            $display("unexpected retirement at %0t: pc %h is not next in program order",
                     $time, retire_pc);
        end else begin
            if (pos > 0) begin
                $display("missing retirements at %0t: %0d instructions before pc %h never retired",
                         $time, pos, retire_pc);
                expected_q = expected_q[pos:$];
            end
            head = expected_q.pop_front();
            check_value("retire_rd_o", 32'(retire_rd), 32'(head.rd));
            check_value("retire_data_o", retire_data, head.data);
            done = (expected_q.size() == 0);
        end
    endtask

    // Four-phase memory with random delay on both ack edges
    initial begin : mem_responder
        int delay;
        wait (rst_n === 1'b1);
        forever begin
            wait_drive_slot();
            if (imem_req === 1'b1) begin
                delay = int'((next_random() >> 16) % 4);
                repeat (delay) wait_drive_slot();
                imem_rdata = fetch_word(imem_addr);
                imem_ack   = 1'b1;
                do begin
                    wait_drive_slot();
                end while (imem_req === 1'b1);
                delay = int'((next_random() >> 16) % 4);
                repeat (delay) wait_drive_slot();
                imem_ack = 1'b0;
            end
        end
    end

    // Sampled mid-cycle, away from the active edge
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (imem_req && prev_req) begin
                check_value("imem_addr_o while imem_req_o high", imem_addr, prev_addr);
            end
            if (imem_req && !prev_req) begin
                check_value("imem_ack_i when imem_req_o rises", 32'(prev_ack), 32'd0);
                if (first_req) begin
                    check_value("first imem_addr_o", imem_addr, RESET_PC);
                    first_req = 1'b0;
                end
            end
            prev_req  = imem_req;
            prev_ack  = imem_ack;
            prev_addr = imem_addr;
            if (retire_valid && !done) begin
                check_retirement();
            end
        end
    end

    initial begin : main_seq
        int n;
        rst_n      = 1'b0;
        imem_ack   = 1'b0;
        imem_rdata = '0;
        build_program();
        run_reference_model();

        for (n = 1; n <= RESET_CYCLES; n++) begin
            @(posedge clk);
            #DRIVE_DLY;
            if (n == RESET_CYCLES) begin
                rst_n = 1'b1;
            end
            @(negedge clk);
            check_value("imem_req_o during reset", 32'(imem_req), 32'd0);
            check_value("retire_valid_o during reset", 32'(retire_valid), 32'd0);
        end

        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            errors++;
            $display("timeout: the run hung, the program did not complete within %0d cycles",
                     TIMEOUT_CYCLES);
        end

        $display("checks: %0d, errors: %0d, retirements still expected: %0d",
                 checks, errors, expected_q.size());
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+bench
design/rv_isa_pkg.sv
design/pipe_pkg.sv
design/if_id_intf.sv
design/fetch.sv
design/decode.sv
design/execute.sv
design/pipeline_top.sv
bench/tb_pipeline_top.sv

// ==== Bender.yml ====
package:
  name: rv32i_pipeline

sources:
  - files:
      - design/rv_isa_pkg.sv
      - design/pipe_pkg.sv
      - design/if_id_intf.sv
      - design/fetch.sv
      - design/decode.sv
      - design/execute.sv
      - design/pipeline_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/tb_pipeline_top.sv
